// ==== common/gme_pkg.sv ====
// shared widths, module ids, field layouts and control codes, imported by every gme block
package gme_pkg;

   // ******************************
   // stream widths
   // ******************************
   localparam int KEY_W  = 512;
   localparam int MD_W   = 256;
   localparam int PHV_W  = 1024;
   localparam int IDX_W  = 16;
   localparam int CPKT_W = 134;

   // this stage and the one after it
   localparam logic [7:0] LMID = 8'd3;
   localparam logic [7:0] NMID = 8'd4;

   // ******************************
   // queue sizing
   // ******************************
   localparam int MD_DEPTH   = 256;
   localparam int PHV_DEPTH  = 256;
   localparam int IDX_DEPTH  = 1024;
   localparam int CTRL_DEPTH = 128;

   // upstream almost-full trips above these fill levels
   localparam int MD_AF_LEVEL  = 250;
   localparam int PHV_AF_LEVEL = 250;
   localparam int IDX_AF_LEVEL = 1020;

   // hit counter memory
   localparam int TBL_DEPTH = 256;
   localparam int TBL_AW    = 8;
   localparam int CNT_W     = 32;

   // ******************************
   // control packet codes
   // ******************************
   localparam logic [1:0] BEAT_HEAD    = 2'b01;
   localparam logic [1:0] BEAT_TAIL    = 2'b10;
   localparam logic [2:0] CMD_READ     = 3'b001;
   localparam logic [2:0] CMD_WRITE    = 3'b010;
   localparam logic [2:0] CMD_READ_ACK = 3'b011;

   // metadata word, msb first
   typedef struct packed {
      logic [167:0] md_high;
      logic [7:0]   next_mid;   // module that handles the packet next
      logic [15:0]  md_mid;
      logic [12:0]  match_idx;  // lookup result merged in here
      logic         idx_valid;
      logic [49:0]  md_low;
   } md_t;

   // one beat of a control packet, msb first
   typedef struct packed {
      logic [1:0]  beat_flag;
      logic [4:0]  beat_rsv;
      logic [2:0]  cmd;
      logic [11:0] seq;
      logic [7:0]  src_mid;
      logic [7:0]  dst_mid;
      logic [20:0] hdr_mid;
      logic [7:0]  tbl_addr;
      logic [34:0] hdr_low;
      logic [31:0] cfg_data;
   } cpkt_t;

endpackage

// ==== hdl/fifo_sync.sv ====
// single-clock show-ahead FIFO with fill count, instantiated for each gme input queue
module fifo_sync #(
   parameter int WIDTH = 8,
   parameter int DEPTH = 16
) (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic [WIDTH-1:0]             din,
   input  logic                         wr,
   input  logic                         rd,
   output logic [WIDTH-1:0]             rdata,
   output logic                         empty,
   output logic                         full,
   output logic [$clog2(DEPTH+1)-1:0]   count
);

   localparam int AW = $clog2(DEPTH);
   localparam int CW = $clog2(DEPTH+1);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [AW-1:0]    wr_ptr;
   logic [AW-1:0]    rd_ptr;
   logic             push;
   logic             pop;

   function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
      return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign empty = (count == '0);
   assign full  = (count == CW'(DEPTH));
   assign pop   = rd && !empty;
   // a full queue still takes a word when the head leaves in the same cycle
   assign push  = wr && (!full || pop);

   // head word is visible before the pop
   assign rdata = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         count <= count + CW'(push) - CW'(pop);
      end
   end

   assert property (@(posedge clk) disable iff (!rst_n) !(wr && full && !rd))
      else $error("fifo_sync: write while full");
   assert property (@(posedge clk) disable iff (!rst_n) !(rd && empty))
      else $error("fifo_sync: read while empty");

endmodule

// ==== hdl/hit_table.sv ====
// dual-port hit counter memory shared by the match sequencer and the control packet path
module hit_table import gme_pkg::*; (
   input  logic              clk,
   input  logic [TBL_AW-1:0] a_addr,
   input  logic              a_we,
   input  logic [CNT_W-1:0]  a_wdata,
   output logic [CNT_W-1:0]  a_rdata,
   input  logic [TBL_AW-1:0] b_addr,
   input  logic              b_we,
   input  logic [CNT_W-1:0]  b_wdata,
   output logic [CNT_W-1:0]  b_rdata
);

   logic [CNT_W-1:0] mem [TBL_DEPTH];
   logic             b_blocked;

   // port a owns the entry on an address clash
   assign b_blocked = a_we && (a_addr == b_addr);

   always_ff @(posedge clk) begin
      if (b_we && !b_blocked) begin
         mem[b_addr] <= b_wdata;
      end
      if (a_we) begin
         mem[a_addr] <= a_wdata;
      end
      // registered reads, old data on a same-cycle write
      a_rdata <= mem[a_addr];
      b_rdata <= mem[b_addr];
   end

endmodule

// ==== match_merge/match_merge.sv ====
// pairs queued metadata and PHV, merges lookup indices into matched items and counts hits
module match_merge import gme_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   input  md_t               md_head,
   input  logic              md_empty,
   output logic              md_rd,
   input  logic [PHV_W-1:0]  phv_head,
   input  logic              phv_empty,
   output logic              phv_rd,
   input  logic [IDX_W-1:0]  idx_head,
   input  logic              idx_empty,
   output logic              idx_rd,
   input  logic              ds_alf,
   output logic [TBL_AW-1:0] tbl_addr,
   output logic              tbl_we,
   output logic [CNT_W-1:0]  tbl_wdata,
   input  logic [CNT_W-1:0]  tbl_rdata,
   output md_t               out_md,
   output logic              out_md_wr,
   output logic [PHV_W-1:0]  out_phv,
   output logic              out_phv_wr
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_TBL_WAIT,
      ST_TBL_SETTLE,
      ST_OUT
   } mm_state_t;

   mm_state_t state;
   logic      hit;
   logic      start;
   md_t       merged;

   // ******************************
   // item selection
   // ******************************
   assign hit = (md_head.next_mid == LMID);

   // a matched item also needs its index from lookup
   assign start = (state == ST_IDLE) && !md_empty && !phv_empty && !ds_alf &&
                  (!hit || !idx_empty);

   assign md_rd  = start;
   assign phv_rd = start;
   assign idx_rd = start && hit;

   always_comb begin
      merged           = md_head;
      merged.next_mid  = NMID;
      merged.match_idx = idx_head[12:0];
      merged.idx_valid = 1'b1;
   end

   // ******************************
   // sequencer
   // ******************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= ST_IDLE;
         out_md_wr  <= 1'b0;
         out_phv_wr <= 1'b0;
         tbl_we     <= 1'b0;
      end else begin
         out_md_wr  <= 1'b0;
         out_phv_wr <= 1'b0;
         tbl_we     <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (start && hit) begin
                  state <= ST_TBL_WAIT;
               end else if (start) begin
                  // pass-through leaves right away
                  out_md_wr  <= 1'b1;
                  out_phv_wr <= 1'b1;
               end
            end
            ST_TBL_WAIT: begin
               state <= ST_TBL_SETTLE;
            end
            ST_TBL_SETTLE: begin
               out_md_wr  <= 1'b1;
               out_phv_wr <= 1'b1;
               tbl_we     <= 1'b1;
               state      <= ST_OUT;
            end
            ST_OUT: begin
               state <= ST_IDLE;
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   // output words wait here until the strobe goes up
   always_ff @(posedge clk) begin
      if (start) begin
         out_md  <= hit ? merged : md_head;
         out_phv <= phv_head;
      end
      if (start && hit) begin
         tbl_addr <= idx_head[TBL_AW-1:0];
      end
      if (state == ST_TBL_SETTLE) begin
         tbl_wdata <= tbl_rdata + 1'b1;
      end
   end

   // pass-through leaves one cycle after its pop
   assert property (@(posedge clk) disable iff (!rst_n)
      (md_rd && !idx_rd) |=> (out_md_wr && out_phv_wr))
      else $error("match_merge: passed item did not leave one cycle after its pop");

   // matched item leaves three cycles after its pop together with the hit count
   assert property (@(posedge clk) disable iff (!rst_n)
      idx_rd |-> ##3 (out_md_wr && out_phv_wr && tbl_we))
      else $error("match_merge: matched item did not leave three cycles after its pop");

endmodule

// ==== cfg_access/cfg_access.sv ====
// control packet handler: reads or writes hit-table entries for this stage, forwards the rest
module cfg_access import gme_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   input  cpkt_t             beat,
   input  logic              beat_empty,
   output logic              beat_rd,
   input  logic              cout_ready,
   output logic [TBL_AW-1:0] tbl_addr,
   output logic              tbl_we,
   output logic [CNT_W-1:0]  tbl_wdata,
   input  logic [CNT_W-1:0]  tbl_rdata,
   output cpkt_t             cout_data,
   output logic              cout_data_wr
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_RD_WAIT,
      ST_REPLY,
      ST_FWD,
      ST_DISCARD
   } cfg_state_t;

   cfg_state_t state;
   logic       to_me;
   logic       is_read;
   logic       is_write;
   logic       is_tail;
   logic       send;
   logic       emit;
   cpkt_t      reply;

   // ******************************
   // header decode
   // ******************************
   assign to_me    = (beat.dst_mid == LMID) && (beat.beat_flag == BEAT_HEAD);
   assign is_read  = to_me && (beat.cmd == CMD_READ);
   assign is_write = to_me && (beat.cmd == CMD_WRITE);
   assign is_tail  = |(beat.beat_flag & BEAT_TAIL);
   assign send     = !beat_empty && cout_ready;

   // the header stays at the queue head until the table access is done
   assign tbl_addr = beat.tbl_addr;

   always_comb begin
      reply          = beat;
      reply.cmd      = CMD_READ_ACK;
      reply.src_mid  = beat.dst_mid;
      reply.dst_mid  = beat.src_mid;
      reply.cfg_data = tbl_rdata;
   end

   always_comb begin
      case (state)
         ST_IDLE:                       beat_rd = send && !is_read && !is_write;
         ST_RD_WAIT, ST_REPLY, ST_FWD:  beat_rd = send;
         ST_DISCARD:                    beat_rd = !beat_empty;
         default:                       beat_rd = 1'b0;
      endcase
   end

   // everything popped goes out except discarded write packets
   assign emit = beat_rd && (state != ST_DISCARD);

   // ******************************
   // packet FSM
   // ******************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state        <= ST_IDLE;
         tbl_we       <= 1'b0;
         cout_data_wr <= 1'b0;
      end else begin
         tbl_we       <= 1'b0;
         cout_data_wr <= emit;
         case (state)
            ST_IDLE: begin
               if (send && is_read) begin
                  state <= ST_RD_WAIT;
               end else if (send && is_write) begin
                  tbl_we <= 1'b1;
                  state  <= ST_DISCARD;
               end else if (send && !is_tail) begin
                  state <= ST_FWD;
               end
            end
            ST_RD_WAIT: begin
               // table data is valid now, reply goes out with the next ready
               if (send) begin
                  state <= is_tail ? ST_IDLE : ST_REPLY;
               end
            end
            ST_REPLY, ST_FWD: begin
               if (send && is_tail) begin
                  state <= ST_IDLE;
               end
            end
            ST_DISCARD: begin
               if (!beat_empty && is_tail) begin
                  state <= ST_IDLE;
               end
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (emit) begin
         cout_data <= (state == ST_RD_WAIT) ? reply : beat;
      end
      if ((state == ST_IDLE) && send && is_write) begin
         tbl_wdata <= beat.cfg_data;
      end
   end

endmodule

// ==== hdl/gme.sv ====
// match engine stage top: key forwarding, input queues, hit table and upstream flow control
module gme import gme_pkg::*; (
   input  logic             clk,
   input  logic             rst_n,
   // from the previous stage
   input  logic [KEY_W-1:0] in_key,
   input  logic             in_key_wr,
   input  md_t              in_md,
   input  logic             in_md_wr,
   input  logic [PHV_W-1:0] in_phv,
   input  logic             in_phv_wr,
   // from lookup
   input  logic [IDX_W-1:0] in_idx,
   input  logic             in_idx_wr,
   // downstream back-pressure
   input  logic             in_key_alf,
   input  logic             in_md_alf,
   input  logic             in_phv_alf,
   // control packets
   input  cpkt_t            cin_data,
   input  logic             cin_data_wr,
   input  logic             cout_ready,
   output logic [KEY_W-1:0] out_key,
   output logic             out_key_wr,
   output md_t              out_md,
   output logic             out_md_wr,
   output logic [PHV_W-1:0] out_phv,
   output logic             out_phv_wr,
   output logic             key_alf,
   output logic             md_alf,
   output logic             phv_alf,
   output logic             idx_alf,
   output logic             cin_ready,
   output cpkt_t            cout_data,
   output logic             cout_data_wr
);

   md_t                               md_head;
   logic                              md_empty;
   logic                              md_rd;
   logic [$clog2(MD_DEPTH+1)-1:0]     md_count;
   logic [PHV_W-1:0]                  phv_head;
   logic                              phv_empty;
   logic                              phv_rd;
   logic [$clog2(PHV_DEPTH+1)-1:0]    phv_count;
   logic [IDX_W-1:0]                  idx_head;
   logic                              idx_empty;
   logic                              idx_rd;
   logic [$clog2(IDX_DEPTH+1)-1:0]    idx_count;
   cpkt_t                             ctrl_head;
   logic                              ctrl_empty;
   logic                              ctrl_full;
   logic                              ctrl_rd;
   logic [TBL_AW-1:0]                 a_addr;
   logic                              a_we;
   logic [CNT_W-1:0]                  a_wdata;
   logic [CNT_W-1:0]                  a_rdata;
   logic [TBL_AW-1:0]                 b_addr;
   logic                              b_we;
   logic [CNT_W-1:0]                  b_wdata;
   logic [CNT_W-1:0]                  b_rdata;

   // ******************************
   // flow control to upstream
   // ******************************
   assign key_alf   = in_key_alf;
   assign md_alf    = in_md_alf || (md_count > MD_AF_LEVEL);
   assign phv_alf   = in_phv_alf || (phv_count > PHV_AF_LEVEL);
   assign idx_alf   = idx_count > IDX_AF_LEVEL;
   assign cin_ready = !ctrl_full;

   // keys go to lookup only when their metadata names this stage
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_key_wr <= 1'b0;
      end else begin
         out_key_wr <= in_key_wr && (in_md.next_mid == LMID);
      end
   end

   always_ff @(posedge clk) begin
      if (in_key_wr && (in_md.next_mid == LMID)) begin
         out_key <= in_key;
      end
   end

   // ******************************
   // input queues
   // ******************************
   fifo_sync #(.WIDTH(MD_W), .DEPTH(MD_DEPTH)) u_md_fifo (
      .clk(clk), .rst_n(rst_n), .din(in_md), .wr(in_md_wr), .rd(md_rd),
      .rdata(md_head), .empty(md_empty), .full(), .count(md_count)
   );

   fifo_sync #(.WIDTH(PHV_W), .DEPTH(PHV_DEPTH)) u_phv_fifo (
      .clk(clk), .rst_n(rst_n), .din(in_phv), .wr(in_phv_wr), .rd(phv_rd),
      .rdata(phv_head), .empty(phv_empty), .full(), .count(phv_count)
   );

   fifo_sync #(.WIDTH(IDX_W), .DEPTH(IDX_DEPTH)) u_idx_fifo (
      .clk(clk), .rst_n(rst_n), .din(in_idx), .wr(in_idx_wr), .rd(idx_rd),
      .rdata(idx_head), .empty(idx_empty), .full(), .count(idx_count)
   );

   fifo_sync #(.WIDTH(CPKT_W), .DEPTH(CTRL_DEPTH)) u_ctrl_fifo (
      .clk(clk), .rst_n(rst_n), .din(cin_data), .wr(cin_data_wr), .rd(ctrl_rd),
      .rdata(ctrl_head), .empty(ctrl_empty), .full(ctrl_full), .count()
   );

   hit_table u_hit_table (
      .clk(clk),
      .a_addr(a_addr), .a_we(a_we), .a_wdata(a_wdata), .a_rdata(a_rdata),
      .b_addr(b_addr), .b_we(b_we), .b_wdata(b_wdata), .b_rdata(b_rdata)
   );

   match_merge u_match_merge (
      .clk(clk), .rst_n(rst_n),
      .md_head(md_head), .md_empty(md_empty), .md_rd(md_rd),
      .phv_head(phv_head), .phv_empty(phv_empty), .phv_rd(phv_rd),
      .idx_head(idx_head), .idx_empty(idx_empty), .idx_rd(idx_rd),
      .ds_alf(in_md_alf || in_phv_alf),
      .tbl_addr(a_addr), .tbl_we(a_we), .tbl_wdata(a_wdata), .tbl_rdata(a_rdata),
      .out_md(out_md), .out_md_wr(out_md_wr), .out_phv(out_phv), .out_phv_wr(out_phv_wr)
   );

   cfg_access u_cfg_access (
      .clk(clk), .rst_n(rst_n),
      .beat(ctrl_head), .beat_empty(ctrl_empty), .beat_rd(ctrl_rd),
      .cout_ready(cout_ready),
      .tbl_addr(b_addr), .tbl_we(b_we), .tbl_wdata(b_wdata), .tbl_rdata(b_rdata),
      .cout_data(cout_data), .cout_data_wr(cout_data_wr)
   );

endmodule

// ==== dv/gme_checker.sv ====
// testbench checker: builds expected outputs from the pattern file and compares the DUT ports
module gme_checker import gme_pkg::*; (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             end_check,
   input  logic             in_key_wr,
   input  md_t              in_md,
   input  logic             in_key_alf,
   input  logic             in_md_alf,
   input  logic             in_phv_alf,
   input  logic [KEY_W-1:0] out_key,
   input  logic             out_key_wr,
   input  md_t              out_md,
   input  logic             out_md_wr,
   input  logic [PHV_W-1:0] out_phv,
   input  logic             out_phv_wr,
   input  logic             key_alf,
   input  logic             md_alf,
   input  logic             phv_alf,
   input  logic             idx_alf,
   input  logic             cin_ready,
   input  cpkt_t            cout_data,
   input  logic             cout_data_wr,
   output int               errors,
   output int               checks
);

   // 64 items of 5 words each
   logic [31:0]      pat [320];
   logic [31:0]      model [256];
   logic [KEY_W-1:0] exp_key [$];
   md_t              exp_md [$];
   logic [PHV_W-1:0] exp_phv [$];
   cpkt_t            exp_beat [$];
   string            key_name [$];
   string            md_name [$];
   string            beat_name [$];
   logic             key_due;
   logic             ended;

   function automatic md_t make_md(input logic [7:0] mid, input logic [31:0] tag);
      md_t m;
      m           = {8{tag}};
      m.next_mid  = mid;
      m.match_idx = '0;
      m.idx_valid = 1'b0;
      return m;
   endfunction

   function automatic cpkt_t make_beat(input logic [1:0] flag, input logic [2:0] cmd,
         input logic [7:0] mid, input logic [15:0] idx, input logic [31:0] tag,
         input logic [31:0] data);
      cpkt_t b;
      b           = '0;
      b.beat_flag = flag;
      b.cmd       = cmd;
      b.seq       = tag[11:0];
      b.src_mid   = 8'h01;
      b.dst_mid   = mid;
      b.hdr_mid   = tag[20:0];
      b.tbl_addr  = idx[7:0];
      b.hdr_low   = {3'b000, tag};
      b.cfg_data  = data;
      return b;
   endfunction

   task automatic check_value(input string name, input logic [PHV_W-1:0] exp,
         input logic [PHV_W-1:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic report_problem(input string what);
      errors++;
      $display("%s", what);
   endtask

   task automatic add_beat(input cpkt_t b, input string name);
      exp_beat.push_back(b);
      beat_name.push_back(name);
   endtask

   // ******************************
   // expected outputs, in item order
   // ******************************
   initial begin
      int          i;
      logic [3:0]  typ;
      logic [7:0]  mid;
      logic [15:0] idx;
      logic [31:0] tag;
      logic [31:0] data;
      md_t         m;
      cpkt_t       b;
      errors  = 0;
      checks  = 0;
      key_due = 1'b0;
      ended   = 1'b0;
      for (i = 0; i < 256; i++) begin
         model[i] = '0;
      end
      for (i = 0; i < 320; i++) begin
         pat[i] = '0;
      end
      $readmemh("dv/gme_patterns.txt", pat);
      i = 0;
      while (i < 64 && pat[5*i] != '0) begin
         typ  = pat[5*i][3:0];
         mid  = pat[5*i+1][7:0];
         idx  = pat[5*i+2][15:0];
         tag  = pat[5*i+3];
         data = pat[5*i+4];
         case (typ)
            4'ha, 4'hb, 4'hf: begin
               if (mid == 8'd3) begin
                  exp_key.push_back({16{tag}});
                  key_name.push_back($sformatf("item %0d key", i));
               end
               if (typ != 4'hf) begin
                  m = make_md(mid, tag);
                  // matched item takes the index and moves on to module 4
                  if (mid == 8'd3) begin
                     m.next_mid  = 8'd4;
                     m.match_idx = idx[12:0];
                     m.idx_valid = 1'b1;
                     model[idx[7:0]] = model[idx[7:0]] + 32'd1;
                  end
                  exp_md.push_back(m);
                  exp_phv.push_back({32{tag}});
                  md_name.push_back($sformatf("item %0d", i));
               end
            end
            4'hc: model[idx[7:0]] = data;
            4'hd: begin
               b          = make_beat(2'b01, 3'b001, mid, idx, tag, data);
               b.cmd      = 3'b011;
               b.src_mid  = mid;
               b.dst_mid  = 8'h01;
               b.cfg_data = model[idx[7:0]];
               add_beat(b, $sformatf("item %0d reply head", i));
               add_beat(make_beat(2'b10, 3'b000, mid, idx, tag, data ^ 32'd1),
                        $sformatf("item %0d reply tail", i));
            end
            4'he: begin
               add_beat(make_beat(2'b01, 3'b001, mid, idx, tag, data),
                        $sformatf("item %0d forward head", i));
               add_beat(make_beat(2'b00, 3'b000, mid, idx, tag, data ^ 32'd1),
                        $sformatf("item %0d forward body", i));
               add_beat(make_beat(2'b10, 3'b000, mid, idx, tag, data ^ 32'd2),
                        $sformatf("item %0d forward tail", i));
            end
            default: ;
         endcase
         i++;
      end
   end

   // ******************************
   // output comparison
   // ******************************
   always @(negedge clk) begin
      string name;
      if (rst_n) begin
         // key leaves exactly one cycle after its input
         if (key_due && !out_key_wr) begin
            report_problem("key for module 3 was not forwarded one cycle after its input");
         end else if (key_due && exp_key.size() == 0) begin
            report_problem("key forwarded with no pattern item left for it");
         end else if (key_due) begin
            check_value(key_name.pop_front(), exp_key.pop_front(), out_key);
         end else if (out_key_wr) begin
            report_problem("key forwarded without metadata for module 3");
         end
         key_due = in_key_wr && (in_md.next_mid == 8'd3);

         if (out_md_wr != out_phv_wr) begin
            report_problem("metadata and PHV strobes did not coincide");
         end else if (out_md_wr && exp_md.size() == 0) begin
            report_problem("metadata and PHV left with no item pending");
         end else if (out_md_wr) begin
            name = md_name.pop_front();
            check_value({name, " md"}, exp_md.pop_front(), out_md);
            check_value({name, " phv"}, exp_phv.pop_front(), out_phv);
         end

         if (cout_data_wr && exp_beat.size() == 0) begin
            report_problem("control beat sent with no packet pending");
         end else if (cout_data_wr) begin
            check_value(beat_name.pop_front(), exp_beat.pop_front(), cout_data);
         end

         // queues hold only a few entries in this test
         // so almost-full just follows the downstream inputs
         check_value("key_alf", in_key_alf, key_alf);
         check_value("md_alf", in_md_alf, md_alf);
         check_value("phv_alf", in_phv_alf, phv_alf);
         check_value("idx_alf", 1'b0, idx_alf);
         check_value("cin_ready", 1'b1, cin_ready);

         if (end_check && !ended) begin
            ended = 1'b1;
            if (exp_key.size() + exp_md.size() + exp_beat.size() != 0) begin
               report_problem($sformatf("outputs never appeared: %0d keys, %0d items, %0d beats",
                                        exp_key.size(), exp_md.size(), exp_beat.size()));
            end
         end
      end
   end

endmodule

// ==== dv/gme_tb.sv ====
// testbench top: drives the match stage from the pattern file and prints the verdict
module gme_tb import gme_pkg::*; ();

   logic             clk;
   logic             rst_n;
   logic [KEY_W-1:0] in_key;
   logic             in_key_wr;
   md_t              in_md;
   logic             in_md_wr;
   logic [PHV_W-1:0] in_phv;
   logic             in_phv_wr;
   logic [IDX_W-1:0] in_idx;
   logic             in_idx_wr;
   logic             in_key_alf;
   logic             in_md_alf;
   logic             in_phv_alf;
   cpkt_t            cin_data;
   logic             cin_data_wr;
   logic             cout_ready;
   logic [KEY_W-1:0] out_key;
   logic             out_key_wr;
   md_t              out_md;
   logic             out_md_wr;
   logic [PHV_W-1:0] out_phv;
   logic             out_phv_wr;
   logic             key_alf;
   logic             md_alf;
   logic             phv_alf;
   logic             idx_alf;
   logic             cin_ready;
   cpkt_t            cout_data;
   logic             cout_data_wr;

   logic [31:0]      pat [320];
   int               n_items;
   logic             hold_ready;
   logic             end_check;
   int               errors;
   int               checks;

   gme u_gme (.*);

   gme_checker u_checker (.*);

   always #50 clk = ~clk;

   // random downstream back-pressure and ready drops
   // ready stays high while a table write goes in
   always @(posedge clk) begin
      cout_ready <= hold_ready || ($urandom_range(3, 0) != 0);
      in_key_alf <= ($urandom_range(7, 0) == 0);
      in_md_alf  <= ($urandom_range(7, 0) == 0);
      in_phv_alf <= ($urandom_range(7, 0) == 0);
   end

   function automatic md_t make_md(input logic [7:0] mid, input logic [31:0] tag);
      md_t m;
      m           = {8{tag}};
      m.next_mid  = mid;
      m.match_idx = '0;
      m.idx_valid = 1'b0;
      return m;
   endfunction

   function automatic cpkt_t make_beat(input logic [1:0] flag, input logic [2:0] cmd,
         input logic [7:0] mid, input logic [15:0] idx, input logic [31:0] tag,
         input logic [31:0] data);
      cpkt_t b;
      b           = '0;
      b.beat_flag = flag;
      b.cmd       = cmd;
      b.seq       = tag[11:0];
      b.src_mid   = 8'h01;
      b.dst_mid   = mid;
      b.hdr_mid   = tag[20:0];
      b.tbl_addr  = idx[7:0];
      b.hdr_low   = {3'b000, tag};
      b.cfg_data  = data;
      return b;
   endfunction

   // ******************************
   // item drivers
   // ******************************
   task automatic send_data(input logic [3:0] typ, input logic [7:0] mid,
         input logic [15:0] idx, input logic [31:0] tag);
      @(posedge clk);
      in_key    <= {16{tag}};
      in_key_wr <= 1'b1;
      in_md     <= make_md(mid, tag);
      in_md_wr  <= (typ != 4'hf);
      in_phv    <= {32{tag}};
      in_phv_wr <= (typ != 4'hf);
      in_idx    <= idx;
      in_idx_wr <= (typ == 4'ha);
      @(posedge clk);
      in_key_wr <= 1'b0;
      in_md_wr  <= 1'b0;
      in_phv_wr <= 1'b0;
      in_idx_wr <= 1'b0;
      in_md     <= '0;
      if (typ != 4'hf) begin
         do @(negedge clk); while (!out_md_wr);
      end
      // hit count is written back the cycle after the output
      repeat (2) @(posedge clk);
   endtask

   task automatic send_ctrl(input logic [2:0] cmd, input logic [7:0] mid,
         input logic [15:0] idx, input logic [31:0] tag, input logic [31:0] data,
         input int beats);
      int k;
      for (k = 0; k < beats; k++) begin
         @(posedge clk);
         cin_data    <= make_beat((k == 0) ? 2'b01 : (k == beats - 1) ? 2'b10 : 2'b00,
                                  (k == 0) ? cmd : 3'b000, mid, idx, tag, data ^ k);
         cin_data_wr <= 1'b1;
      end
      @(posedge clk);
      cin_data_wr <= 1'b0;
   endtask

   task automatic wait_tail();
      do @(negedge clk); while (!(cout_data_wr && cout_data.beat_flag == 2'b10));
   endtask

   task automatic run_item(input logic [3:0] typ, input logic [7:0] mid,
         input logic [15:0] idx, input logic [31:0] tag, input logic [31:0] data);
      case (typ)
         4'ha, 4'hb, 4'hf: send_data(typ, mid, idx, tag);
         4'hc: begin
            @(negedge clk);
            hold_ready = 1'b1;
            send_ctrl(3'b010, mid, idx, tag, data, 2);
            // header is taken and the entry written within three cycles
            repeat (3) @(posedge clk);
            @(negedge clk);
            hold_ready = 1'b0;
         end
         4'hd: begin
            send_ctrl(3'b001, mid, idx, tag, data, 2);
            wait_tail();
         end
         4'he: begin
            send_ctrl(3'b001, mid, idx, tag, data, 3);
            wait_tail();
         end
         default: $display("pattern item of unknown type %h skipped", typ);
      endcase
   endtask

   // ******************************
   // main sequence
   // ******************************
   initial begin
      int i;
      clk         = 1'b0;
      rst_n       = 1'b0;
      in_key      = '0;
      in_key_wr   = 1'b0;
      in_md       = '0;
      in_md_wr    = 1'b0;
      in_phv      = '0;
      in_phv_wr   = 1'b0;
      in_idx      = '0;
      in_idx_wr   = 1'b0;
      in_key_alf  = 1'b0;
      in_md_alf   = 1'b0;
      in_phv_alf  = 1'b0;
      cin_data    = '0;
      cin_data_wr = 1'b0;
      cout_ready  = 1'b1;
      hold_ready  = 1'b0;
      end_check   = 1'b0;
      n_items     = 0;
      void'($urandom(32'h9df0_465f));
      for (i = 0; i < 320; i++) begin
         pat[i] = '0;
      end
      $readmemh("dv/gme_patterns.txt", pat);
      while (n_items < 64 && pat[5*n_items] != '0) begin
         n_items++;
      end
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      for (i = 0; i < n_items; i++) begin
         repeat ($urandom_range(3, 0)) @(posedge clk);
         run_item(pat[5*i][3:0], pat[5*i+1][7:0], pat[5*i+2][15:0], pat[5*i+3], pat[5*i+4]);
      end
      repeat (8) @(posedge clk);
      end_check <= 1'b1;
      @(negedge clk);
      @(posedge clk);
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // watchdog, 60 cycles per item plus 200
   initial begin
      wait (rst_n === 1'b1);
      #(100 * (60 * n_items + 200));
      $display("watchdog: the run did not complete in time");
      $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== dv/gme_patterns.txt ====
// columns: type mid index tag data, all hex
// type a matched item, b passed item, c table write, d table read, e foreign control, f key only
c 03 0015 00000101 00000010
c 03 002a 00000102 000000f0
a 03 0115 1234abcd 00000000
b 05 0000 55aa0011 00000000
a 03 1f15 0badf00d 00000000
f 03 0000 77770001 00000000
f 07 0000 77770002 00000000
d 03 0015 00000201 00000000
a 03 002a 3c3c3c3c 00000000
b 02 0000 99990002 00000000
e 06 0040 00000301 cafe0001
d 03 002a 00000202 00000000
c 03 0015 00000103 00000005
a 03 e215 abcdef01 00000000
a 03 0015 abcdef02 00000000
d 03 0015 00000203 00000000
e 01 0011 00000302 beef0002
b 09 0000 10203040 00000000
d 03 0015 00000204 00000000

// ==== gme.f ====
common/gme_pkg.sv
hdl/fifo_sync.sv
hdl/hit_table.sv
match_merge/match_merge.sv
cfg_access/cfg_access.sv
hdl/gme.sv
dv/gme_checker.sv
dv/gme_tb.sv

// ==== Makefile ====
TOP = gme_tb

.PHONY: help test clean

help:
	@echo "make test   build the gme testbench with Verilator and run it"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f gme.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
